// ==== Bender.yml ====
package:
  name: fp_to_dec

sources:
  # design, in compile order
  - files:
      - source/fp_dec_pkg.sv
      - source/flp_classify.sv
      - source/mant_align.sv
      - source/dec_result_reg.sv
      - source/fp_to_dec_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/fp_to_dec_assert.sv
      - bench/fp_to_dec_tb.sv

// ==== bench/fp_to_dec_assert.sv ====
`timescale 1ns/1ps

module fp_to_dec_assert
	import fp_dec_pkg::*;
(
	input logic     clk_i,
	input logic     rst_n_i,
	input logic     flp_valid_i,
	input dec_out_t dec_o,
	input logic     dec_valid_o
);

	int fail_count = 0;  // read back by the testbench

	// two register stages between strobe and result
	property p_latency;
		@(posedge clk_i) disable iff (!rst_n_i)
		dec_valid_o == $past(flp_valid_i, 2);
	endproperty

	property p_range_zero;
		@(posedge clk_i) disable iff (!rst_n_i)
		dec_o.range_err |-> (dec_o.int_part == '0 && dec_o.frac_milli == '0);
	endproperty

	// eighths only
	property p_milli_step;
		@(posedge clk_i) disable iff (!rst_n_i)
		(dec_o.frac_milli % 125 == 0) && (dec_o.frac_milli < 1000);
	endproperty

	property p_reset_quiet;
		@(posedge clk_i)
		!rst_n_i |-> !dec_valid_o;
	endproperty

	a_latency: assert property (p_latency)
		else begin
			$error("dec_valid_o does not follow flp_valid_i by two cycles");
			fail_count++;
		end
	a_range_zero: assert property (p_range_zero)
		else begin
			$error("range error with nonzero reading");
			fail_count++;
		end
	a_milli_step: assert property (p_milli_step)
		else begin
			$error("frac_milli off the 125 grid");
			fail_count++;
		end
	a_reset_quiet: assert property (p_reset_quiet)
		else begin
			$error("dec_valid_o high during reset");
			fail_count++;
		end

endmodule

bind fp_to_dec_top fp_to_dec_assert u_fp_to_dec_assert (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.flp_valid_i (flp_valid_i),
	.dec_o       (dec_o),
	.dec_valid_o (dec_valid_o)
);

// ==== bench/fp_to_dec_tb.sv ====
`timescale 1ns/1ps

module fp_to_dec_tb
	import fp_dec_pkg::*;
();

	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_WORDS = 200;
	localparam int TOTAL_WORDS  = 4 + 4 + 9 + 6 + RANDOM_WORDS;
	localparam int MAX_CYCLES   = 10 * TOTAL_WORDS + RESET_CYCLES;
	localparam int DRAIN_CYCLES = 6;  // enough for the two-stage latency

	logic     clk_i;
	logic     rst_n_i;
	flp_t     flp_i;
	logic     flp_valid_i;
	dec_out_t dec_o;
	logic     dec_valid_o;

	dec_out_t exp_q[$];  // expected readings in send order
	int       due_q[$];  // cycle each reading is due
	int       cyc;
	int       errors;
	int       checks;
	int       words;
	integer   seed;

	fp_to_dec_top u_fp_to_dec_top (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.flp_i       (flp_i),
		.flp_valid_i (flp_valid_i),
		.dec_o       (dec_o),
		.dec_valid_o (dec_valid_o)
	);

	initial begin
		clk_i = 1'b0;
	end

	always #20 clk_i = ~clk_i;

	// cycle count doubles as the run limit
	always @(posedge clk_i) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cyc);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error %s got %h expected %h", name, got, expected);
		end
	endtask

	// exact truncation of 1.mant * 2^(exp-127) scaled by 8 for the eighths
	function automatic dec_out_t expected_reading(input flp_t w);
		dec_out_t        r;
		int              e;
		int              sh;
		longint unsigned scaled;
		r      = '0;
		r.sign = w.sign;
		e      = int'(w.exp) - 127;
		if (w.exp == 8'hff || e >= 24) begin
			r.range_err = 1'b1;
		end else if (w.exp != 8'h00) begin
			sh     = e + 3 - 23;
			scaled = {40'd0, 1'b1, w.mant};
			if (sh >= 0) begin
				scaled = scaled << sh;
			end else if (-sh < 64) begin
				scaled = scaled >> (-sh);
			end else begin
				scaled = 0;
			end
			r.int_part   = scaled[26:3];
			r.frac_milli = 10'(int'(scaled[2:0]) * 125);
		end
		return r;
	endfunction

	// outputs are settled by the falling edge
	always @(negedge clk_i) begin
		dec_out_t exp_r;
		int       due;
		if (rst_n_i && dec_valid_o) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("valid pulse seen with no word outstanding at cycle %0d", cyc);
			end else begin
				exp_r = exp_q.pop_front();
				due   = due_q.pop_front();
				check_value("dec_valid_o cycle", cyc, due);
				check_value("dec_o.sign", dec_o.sign, exp_r.sign);
				check_value("dec_o.int_part", dec_o.int_part, exp_r.int_part);
				check_value("dec_o.frac_milli", dec_o.frac_milli, exp_r.frac_milli);
				check_value("dec_o.range_err", dec_o.range_err, exp_r.range_err);
			end
		end
	end

	task automatic send_word(input logic [31:0] bits);
		@(posedge clk_i);
		#2;
		flp_i       = flp_t'(bits);
		flp_valid_i = 1'b1;
		exp_q.push_back(expected_reading(flp_t'(bits)));
		due_q.push_back(cyc + 2);  // sampled next edge and out two edges later
		words++;
	endtask

	task automatic idle_cycle();
		@(posedge clk_i);
		#2;
		flp_valid_i = 1'b0;
	endtask

	task automatic drain_results();
		int n;
		n = 0;
		idle_cycle();
		while (exp_q.size() > 0 && n < DRAIN_CYCLES) begin
			@(posedge clk_i);
			n++;
		end
		if (exp_q.size() > 0) begin
			errors += exp_q.size();
			$display("no valid pulse arrived for %0d words", exp_q.size());
			exp_q.delete();
			due_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int err_before, input int word_before);
		$display("test %-18s %0d words, %0d errors", name, words - word_before,
			errors - err_before);
	endtask

	task automatic test_positive();
		int e0;
		int w0;
		e0 = errors;
		w0 = words;
		send_word(32'h3f80_0000);  // 1.0
		idle_cycle();
		send_word(32'h40b8_0000);  // 5.75
		idle_cycle();
		send_word(32'h447a_2000);  // 1000.5
		idle_cycle();
		send_word(32'h4aff_fffe);  // 8388607.0
		drain_results();
		report_test("positive", e0, w0);
	endtask

	task automatic test_neg_fraction();
		int e0;
		int w0;
		e0 = errors;
		w0 = words;
		send_word(32'hbf00_0000);  // -0.5
		send_word(32'hbf60_0000);  // -0.875
		send_word(32'h3e99_999a);  // 0.3
		send_word(32'h3c23_d70a);  // 0.01
		drain_results();
		report_test("neg_fraction", e0, w0);
	endtask

	task automatic test_special();
		int e0;
		int w0;
		e0 = errors;
		w0 = words;
		send_word(32'h0000_0000);
		send_word(32'h8000_0000);
		send_word(32'h0000_0001);  // smallest subnormal
		send_word(32'h807f_ffff);
		send_word(32'h4b80_0000);  // 2^24
		send_word(32'h7149_f2ca);  // 1e30
		send_word(32'h7f80_0000);
		send_word(32'hff80_0000);
		send_word(32'h7fc0_0000);  // quiet nan
		drain_results();
		report_test("special", e0, w0);
	endtask

	task automatic test_back_to_back();
		int e0;
		int w0;
		e0 = errors;
		w0 = words;
		send_word(32'h4000_0000);
		send_word(32'hc060_0000);
		send_word(32'h3e00_0000);
		send_word(32'h4b80_0000);
		send_word(32'h4146_0000);
		send_word(32'h0000_0000);
		drain_results();
		report_test("back_to_back", e0, w0);
	endtask

	task automatic test_random_sweep();
		int          e0;
		int          w0;
		logic [31:0] r_exp;
		logic [31:0] r_body;
		flp_t        w;
		e0 = errors;
		w0 = words;
		for (int i = 0; i < RANDOM_WORDS; i++) begin
			r_exp  = $random(seed);
			r_body = $random(seed);
			w.sign = r_body[31];
			w.exp  = 8'(100 + (r_exp[15:0] % 61));  // 100 .. 160
			w.mant = r_body[22:0];
			send_word(w);
		end
		drain_results();
		report_test("random_sweep", e0, w0);
	endtask

	initial begin
		cyc         = 0;
		errors      = 0;
		checks      = 0;
		words       = 0;
		seed        = 32'h2dc7;
		rst_n_i     = 1'b0;
		flp_i       = '0;
		flp_valid_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;
		test_positive();
		test_neg_fraction();
		test_special();
		test_back_to_back();
		test_random_sweep();
		errors += u_fp_to_dec_top.u_fp_to_dec_assert.fail_count;  // bound assertion failures
		$display("summary: %0d words, %0d checks, %0d errors", words, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== fp_to_dec.f ====
source/fp_dec_pkg.sv
source/flp_classify.sv
source/mant_align.sv
source/dec_result_reg.sv
source/fp_to_dec_top.sv
bench/fp_to_dec_assert.sv
bench/fp_to_dec_tb.sv

// ==== source/dec_result_reg.sv ====
`timescale 1ns/1ps

module dec_result_reg
	import fp_dec_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  flp_stage_t stage_i,
	input  logic       stage_valid_i,
	input  align_t     align_i,
	output dec_out_t   dec_o,
	output logic       dec_valid_o
);

	logic [MILLI_W-1:0] milli;
	logic               range_err;
	dec_out_t           dec_d;

	// eighths to thousandths
	always_comb begin
		case (align_i.frac_bits)
			3'd0:    milli = 10'd0;
			3'd1:    milli = 10'd125;
			3'd2:    milli = 10'd250;
			3'd3:    milli = 10'd375;
			3'd4:    milli = 10'd500;
			3'd5:    milli = 10'd625;
			3'd6:    milli = 10'd750;
			default: milli = 10'd875;
		endcase
	end

	always_comb begin
		range_err = (stage_i.cls == CLS_RANGE);
	end

	always_comb begin
		dec_d.sign      = stage_i.sign;  // kept even on range error
		dec_d.range_err = range_err;
		if (range_err) begin
			dec_d.int_part   = '0;
			dec_d.frac_milli = '0;
		end else begin
			dec_d.int_part   = align_i.int_part;
			dec_d.frac_milli = milli;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= stage_valid_i;
		end
	end

	// reading holds between results
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_o <= '0;
		end else if (stage_valid_i) begin
			dec_o <= dec_d;
		end
	end

endmodule

// ==== source/flp_classify.sv ====
`timescale 1ns/1ps

module flp_classify
	import fp_dec_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  flp_t       flp_i,
	input  logic       flp_valid_i,
	output flp_stage_t stage_o,
	output logic       stage_valid_o
);

	logic [EXP_W:0]     unb_sum;     // carry plus difference
	logic               exp_nonneg;
	logic [EXP_W-1:0]   unb_exp;
	logic [EXP_W-1:0]   exp_mag;
	logic [SHAMT_W-1:0] shamt_sat;
	exp_cls_e           cls_d;
	flp_stage_t         stage_d;

	// exp - 127 as exp + ~127 + 1, carry means exp >= 127
	always_comb begin
		unb_sum    = {1'b0, flp_i.exp} + {1'b0, ~EXP_BIAS} + 1'b1;
		exp_nonneg = unb_sum[EXP_W];
		unb_exp    = unb_sum[EXP_W-1:0];
	end

	// magnitude of the unbiased exponent
	always_comb begin
		if (exp_nonneg) begin
			exp_mag = unb_exp;
		end else begin
			exp_mag = ~unb_exp + 8'd1;  // two's complement negate
		end
	end

	// anything past 31 shifts everything out anyway
	always_comb begin
		if (|exp_mag[EXP_W-1:SHAMT_W]) begin
			shamt_sat = '1;
		end else begin
			shamt_sat = exp_mag[SHAMT_W-1:0];
		end
	end

	always_comb begin
		if (flp_i.exp == '0) begin
			cls_d = CLS_ZERO;
		end else if (flp_i.exp == '1) begin
			cls_d = CLS_RANGE;  // inf and nan
		end else if (exp_nonneg) begin
			if (exp_mag > MAX_POS_EXP) begin
				cls_d = CLS_RANGE;
			end else begin
				cls_d = CLS_POS_EXP;
			end
		end else begin
			cls_d = CLS_NEG_EXP;
		end
	end

	always_comb begin
		stage_d.sign  = flp_i.sign;
		stage_d.cls   = cls_d;
		stage_d.shamt = shamt_sat;
		stage_d.mant  = flp_i.mant;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stage_valid_o <= 1'b0;
		end else begin
			stage_valid_o <= flp_valid_i;
		end
	end

	// payload only moves on a strobe
	always_ff @(posedge clk_i) begin
		if (flp_valid_i) begin
			stage_o <= stage_d;
		end
	end

endmodule

// ==== source/fp_dec_pkg.sv ====
package fp_dec_pkg;

	// IEEE-754 single precision field widths
	localparam int EXP_W   = 8;
	localparam int MANT_W  = 23;

	localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;

	// fixed-point reading widths
	localparam int INT_W   = 24;      // integer part, hidden one plus mantissa
	localparam int FRAC_W  = 3;       // eighths below the binary point
	localparam int MILLI_W = 10;      // 0 .. 875 thousandths

	localparam int SHAMT_W     = 5;   // exponent magnitude, saturated
	localparam int MAX_POS_EXP = 23;  // largest exponent with a fitting integer part

	// raw float word
	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [MANT_W-1:0] mant;
	} flp_t;

	// exponent class after unbias
	typedef enum logic [1:0] {
		CLS_ZERO    = 2'd0,  // zero and subnormals
		CLS_POS_EXP = 2'd1,  // 0 .. 23
		CLS_NEG_EXP = 2'd2,  // below zero
		CLS_RANGE   = 2'd3   // too large, inf, nan
	} exp_cls_e;

	// first pipeline stage
	typedef struct packed {
		logic                sign;
		exp_cls_e            cls;
		logic [SHAMT_W-1:0]  shamt;
		logic [MANT_W-1:0]   mant;
	} flp_stage_t;

	// aligned magnitude
	typedef struct packed {
		logic [INT_W-1:0]  int_part;
		logic [FRAC_W-1:0] frac_bits;
	} align_t;

	// decimal reading
	typedef struct packed {
		logic               sign;
		logic [INT_W-1:0]   int_part;
		logic [MILLI_W-1:0] frac_milli;
		logic               range_err;
	} dec_out_t;

endpackage

// ==== source/fp_to_dec_top.sv ====
`timescale 1ns/1ps

module fp_to_dec_top
	import fp_dec_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  flp_t     flp_i,
	input  logic     flp_valid_i,
	output dec_out_t dec_o,
	output logic     dec_valid_o
);

	flp_stage_t stage;
	logic       stage_valid;
	align_t     align;

	// stage 1, unbias and classify
	flp_classify u_classify (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.flp_i         (flp_i),
		.flp_valid_i   (flp_valid_i),
		.stage_o       (stage),
		.stage_valid_o (stage_valid)
	);

	// combinational, between the two registers
	mant_align u_align (
		.stage_i (stage),
		.align_o (align)
	);

	// stage 2, decimal reading
	dec_result_reg u_result (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.stage_i       (stage),
		.stage_valid_i (stage_valid),
		.align_i       (align),
		.dec_o         (dec_o),
		.dec_valid_o   (dec_valid_o)
	);

endmodule

// ==== source/mant_align.sv ====
`timescale 1ns/1ps

module mant_align
	import fp_dec_pkg::*;
(
	input  flp_stage_t stage_i,
	output align_t     align_o
);

	localparam int FRAME_W = INT_W + FRAC_W;  // integer bits over three fraction bits
	localparam int SHR_W   = 6;               // up to 23 + 31

	logic [INT_W-1:0]   hid_mant;
	logic [FRAME_W-1:0] frame;
	logic [FRAME_W-1:0] aligned;
	logic [SHR_W-1:0]   shr;
	logic               in_window;

	// hidden one in front, binary point below bit 0 of the mantissa
	always_comb begin
		hid_mant = {1'b1, stage_i.mant};
		frame    = {hid_mant, {FRAC_W{1'b0}}};
	end

	// The frame holds 1.mant scaled by 2^23. A positive exponent e leaves
	// 23-e bits to drop, a negative one adds its magnitude on top, so both
	// directions reduce to one right shift.
	always_comb begin
		case (stage_i.cls)
			CLS_POS_EXP: begin
				shr       = SHR_W'(MAX_POS_EXP) - {1'b0, stage_i.shamt};
				in_window = 1'b1;
			end
			CLS_NEG_EXP: begin
				shr       = SHR_W'(MAX_POS_EXP) + {1'b0, stage_i.shamt};
				in_window = 1'b1;
			end
			default: begin
				shr       = '0;
				in_window = 1'b0;  // zero, subnormal or out of range
			end
		endcase
	end

	always_comb begin
		aligned = frame >> shr;  // large shifts clear the frame
	end

	// negative exponents always shift past the integer field
	always_comb begin
		if (in_window) begin
			align_o.int_part  = aligned[FRAME_W-1:FRAC_W];
			align_o.frac_bits = aligned[FRAC_W-1:0];
		end else begin
			align_o.int_part  = '0;
			align_o.frac_bits = '0;
		end
	end

endmodule
